//--- rv_core.f
+incdir+.
rv_core_pkg.sv
rv_core_if.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
rv_core_props.sv
rv_core_tb.sv

//--- run.sh
#!/bin/bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f rv_core.f --top-module rv_core_tb \
  -Mdir "$BUILD_DIR" -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/rv_core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

//--- rv_core_tb.sv
// rv_core testbench
// table-driven RV64I stimulus, reference register model and write-back checks
`timescale 1ns/100ps

module rv_core_tb
  import rv_core_pkg::*;
();

  logic      clk = 1'b0;
  logic      rst_n;
  logic      i_instr_valid;
  instr_t    i_instr;
  logic      o_wb_valid;
  logic      o_wb_rd_wen;
  reg_addr_t o_wb_rd_addr;
  xlen_t     o_wb_rd_data;

  // stimulus table, and expected results for the valid entries only
  instr_t    tab_instr [$];
  logic      tab_valid [$];
  logic      exp_wen [$];
  reg_addr_t exp_addr [$];
  xlen_t     exp_data [$];
  int        exp_group [$];
  xlen_t     model_regs [32];
  integer    seed;
  int        n_checks;
  int        n_errors;
  int        n_done;
  logic      table_ready;
  string     group_name [6] = '{"reset reads", "immediate ops", "register ops",
                                "dependencies", "bubbles and random", "no-write cases"};

  rv_core UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_instr_valid(i_instr_valid),
    .i_instr      (i_instr),
    .o_wb_valid   (o_wb_valid),
    .o_wb_rd_wen  (o_wb_rd_wen),
    .o_wb_rd_addr (o_wb_rd_addr),
    .o_wb_rd_data (o_wb_rd_data)
  );

  bind rv_core rv_core_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_instr_valid(i_instr_valid),
    .i_wb_valid   (o_wb_valid),
    .i_wb_rd_wen  (o_wb_rd_wen),
    .i_wb_rd_addr (o_wb_rd_addr)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  function automatic instr_t op_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic instr_t op_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  // RV64I semantics on the model registers
  task automatic model_step(input instr_t ins, output logic wen, output xlen_t res);
    logic [6:0] opc;
    logic [2:0] f3;
    xlen_t      a;
    xlen_t      b;
    logic       ok;
    opc = ins[6:0];
    f3  = ins[14:12];
    a   = model_regs[ins[19:15]];
    b   = (opc == 7'h13) ? {{52{ins[31]}}, ins[31:20]} : model_regs[ins[24:20]];
    ok  = 1'b1;
    res = '0;
    if (opc == 7'h37) begin
      res = {{32{ins[31]}}, ins[31:12], 12'h000};
    end else if (opc == 7'h13 || opc == 7'h33) begin
      if (opc == 7'h33)
        ok = ins[31:25] == 7'h00 || (ins[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      case (f3)
        3'd0: res = (opc == 7'h33 && ins[30]) ? a - b : a + b;
        3'd1: res = a << b[5:0];
        3'd2: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'd3: res = (a < b) ? 64'd1 : 64'd0;
        3'd4: res = a ^ b;
        3'd5: begin
          if (ins[30])
            res = $signed(a) >>> b[5:0];
          else
            res = a >> b[5:0];
        end
        3'd6: res = a | b;
        default: res = a & b;
      endcase
    end else begin
      ok = 1'b0;
    end
    wen = ok && (ins[11:7] != 5'd0);
    if (wen)
      model_regs[ins[11:7]] = res;
  endtask

  task automatic add_entry(input logic valid, input instr_t ins, input int group);
    logic  wen;
    xlen_t res;
    tab_valid.push_back(valid);
    tab_instr.push_back(ins);
    if (valid) begin
      model_step(ins, wen, res);
      exp_wen.push_back(wen);
      exp_addr.push_back(ins[11:7]);
      exp_data.push_back(res);
      exp_group.push_back(group);
    end
  endtask

  task automatic fill_table();
    logic [31:0] r;
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    for (int i = 1; i < 32; i++)
      add_entry(1'b1, op_i(12'h000, i[4:0], 3'd0, i[4:0]), 0);
    add_entry(1'b1, op_i(12'hffb, 5'd0, 3'd0, 5'd1), 1);
    add_entry(1'b1, op_i(12'h123, 5'd0, 3'd0, 5'd2), 1);
    add_entry(1'b1, op_i(12'hffc, 5'd1, 3'd2, 5'd3), 1);
    add_entry(1'b1, op_i(12'h005, 5'd1, 3'd3, 5'd4), 1);
    add_entry(1'b1, op_i(12'hfff, 5'd2, 3'd4, 5'd5), 1);
    add_entry(1'b1, op_i(12'h0f0, 5'd1, 3'd6, 5'd6), 1);
    add_entry(1'b1, op_i(12'h7f0, 5'd1, 3'd7, 5'd7), 1);
    add_entry(1'b1, op_i({6'b000000, 6'd40}, 5'd2, 3'd1, 5'd8), 1);
    add_entry(1'b1, op_i({6'b000000, 6'd60}, 5'd1, 3'd5, 5'd9), 1);
    add_entry(1'b1, op_i({6'b010000, 6'd33}, 5'd1, 3'd5, 5'd10), 1);
    add_entry(1'b1, {20'h80001, 5'd12, 7'b0110111}, 1);
    add_entry(1'b1, op_i(12'd40, 5'd0, 3'd0, 5'd13), 2);
    add_entry(1'b1, op_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd14), 2);
    add_entry(1'b1, op_r(7'h20, 5'd2, 5'd0, 3'd0, 5'd15), 2);
    add_entry(1'b1, op_r(7'h00, 5'd13, 5'd2, 3'd1, 5'd16), 2);
    add_entry(1'b1, op_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd17), 2);
    add_entry(1'b1, op_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd18), 2);
    add_entry(1'b1, op_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd19), 2);
    add_entry(1'b1, op_r(7'h00, 5'd13, 5'd12, 3'd5, 5'd20), 2);
    add_entry(1'b1, op_r(7'h20, 5'd13, 5'd12, 3'd5, 5'd21), 2);
    add_entry(1'b1, op_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd22), 2);
    add_entry(1'b1, op_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd23), 2);
    // producer, forwarded consumer, then register-file reads
    add_entry(1'b1, op_i(12'd7, 5'd0, 3'd0, 5'd24), 3);
    add_entry(1'b1, op_i(12'd1, 5'd24, 3'd0, 5'd25), 3);
    add_entry(1'b1, op_r(7'h00, 5'd25, 5'd24, 3'd0, 5'd26), 3);
    add_entry(1'b0, op_i(12'h3ff, 5'd0, 3'd0, 5'd24), 3);
    add_entry(1'b1, op_r(7'h00, 5'd26, 5'd24, 3'd0, 5'd28), 3);
    for (int i = 0; i < 12; i++) begin
      r = $random(seed);
      if (r[31])
        add_entry(1'b0, r, 4);
      if (r[30])
        add_entry(1'b1, op_i(r[11:0], r[16:12], 3'd0, r[21:17]), 4);
      else
        add_entry(1'b1, op_r(7'h00, r[26:22], r[16:12], 3'd6, r[21:17]), 4);
    end
    add_entry(1'b1, op_i(12'd5, 5'd1, 3'd0, 5'd0), 5);
    add_entry(1'b1, op_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd29), 5);
    add_entry(1'b1, op_i(12'h055, 5'd0, 3'd0, 5'd30), 5);
    // a load and a MUL both aimed at x30
    add_entry(1'b1, {12'h000, 5'd1, 3'd3, 5'd30, 7'b0000011}, 5);
    add_entry(1'b1, op_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd30), 5);
    add_entry(1'b1, op_i(12'h000, 5'd30, 3'd0, 5'd31), 5);
  endtask

  task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  initial begin : wb_checker
    int k;
    int err_base;
    k = 0;
    err_base = 0;
    wait (table_ready);
    forever begin
      @(negedge clk);
      if (o_wb_valid === 1'b1) begin
        if (k >= exp_wen.size()) begin
          n_errors++;
          $display("unexpected write-back at %0t ns after the last table entry", $time);
        end else begin
          compare(o_wb_rd_wen, exp_wen[k], $sformatf("write-back %0d rd_wen", k));
          compare(o_wb_rd_addr, exp_addr[k], $sformatf("write-back %0d rd_addr", k));
          if (exp_wen[k])
            compare(o_wb_rd_data, exp_data[k], $sformatf("write-back %0d rd_data", k));
          k++;
          n_done = k;
          if (k == exp_wen.size() || exp_group[k] != exp_group[k-1]) begin
            $display("group %0d %s done, %0d errors", exp_group[k-1],
                     group_name[exp_group[k-1]], n_errors - err_base);
            err_base = n_errors;
          end
        end
      end
    end
  end

  initial begin : watchdog
    int limit_ns;
    wait (table_ready);
    limit_ns = (tab_valid.size() + 20) * 4;
    #(limit_ns);
    $display("watchdog expired after %0d ns, write-backs still missing", limit_ns);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    i_instr_valid = 1'b0;
    i_instr = '0;
    seed = 32'h9457d3d4;
    n_checks = 0;
    n_errors = 0;
    n_done = 0;
    table_ready = 1'b0;
    fill_table();
    table_ready = 1'b1;
    repeat (2) begin
      @(negedge clk);
      compare(o_wb_valid, 1'b0, "o_wb_valid in reset");
    end
    rst_n = 1'b1;
    repeat (2) begin
      @(negedge clk);
      compare(o_wb_valid, 1'b0, "o_wb_valid before first instruction");
    end
    foreach (tab_valid[i]) begin
      @(negedge clk);
      i_instr_valid = tab_valid[i];
      i_instr = tab_instr[i];
    end
    @(negedge clk);
    i_instr_valid = 1'b0;
    i_instr = '0;
    wait (n_done == exp_wen.size());
    repeat (4) @(negedge clk);
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- rv_core_props.sv
// rv_core pipeline properties
// write-back timing and register-write sanity, bound into rv_core
`timescale 1ns/100ps

module rv_core_props
  import rv_core_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      i_instr_valid,
  input logic      i_wb_valid,
  input logic      i_wb_rd_wen,
  input reg_addr_t i_wb_rd_addr
);

  // write-back pulse lands exactly two edges after the accepted strobe
  a_wb_latency: assert property (@(posedge clk) disable iff (!rst_n)
    i_wb_valid == $past(i_instr_valid, 2))
    else $error("write-back valid does not follow the instruction strobe by two edges");

  a_wen_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    i_wb_rd_wen |-> i_wb_valid)
    else $error("register write enable seen without write-back valid");

  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    i_wb_rd_wen |-> (i_wb_rd_addr != '0))
    else $error("register write enable seen for x0");

endmodule

//--- rv_core.sv
// rv_core
// three-stage RV64I integer pipeline: decode, execute, result
`timescale 1ns/100ps

module rv_core
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_instr_valid,
  input  instr_t    i_instr,
  output logic      o_wb_valid,
  output logic      o_wb_rd_wen,
  output reg_addr_t o_wb_rd_addr,
  output xlen_t     o_wb_rd_data
);

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xlen_t     rs1_data;
  xlen_t     rs2_data;

  dec_ex_if dec_ex ();
  wb_if     wb ();

  rv_decode u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .o_dec         (dec_ex.dec)
  );

  rv_execute u_execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_dec      (dec_ex.ex),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_wb       (wb.src)
  );

  rv_result u_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_wb         (wb.dst),
    .i_rs1_addr   (rs1_addr),
    .i_rs2_addr   (rs2_addr),
    .o_rs1_data   (rs1_data),
    .o_rs2_data   (rs2_data),
    .o_wb_valid   (o_wb_valid),
    .o_wb_rd_wen  (o_wb_rd_wen),
    .o_wb_rd_addr (o_wb_rd_addr),
    .o_wb_rd_data (o_wb_rd_data)
  );

endmodule

//--- rv_result.sv
// rv_result
// integer register file, written from the write-back bundle, with two read ports
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_result
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  wb_if.dst         i_wb,
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  output xlen_t     o_rs1_data,
  output xlen_t     o_rs2_data,
  output logic      o_wb_valid,
  output logic      o_wb_rd_wen,
  output reg_addr_t o_wb_rd_addr,
  output xlen_t     o_wb_rd_data
);

  xlen_t regs [`NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.valid && i_wb.rd_wen) begin
      regs[i_wb.rd_addr] <= i_wb.rd_data;
    end
  end

  // x0 reads as zero
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

  assign o_wb_valid   = i_wb.valid;
  assign o_wb_rd_wen  = i_wb.rd_wen;
  assign o_wb_rd_addr = i_wb.rd_addr;
  assign o_wb_rd_data = i_wb.rd_data;

endmodule

//--- rv_execute.sv
// rv_execute
// operand read with result-stage forwarding, ALU, and the write-back register
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_execute
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  dec_ex_if.ex      i_dec,
  output reg_addr_t o_rs1_addr,
  output reg_addr_t o_rs2_addr,
  input  xlen_t     i_rs1_data,
  input  xlen_t     i_rs2_data,
  wb_if.src         o_wb
);

  logic       wb_hit;
  logic       fwd_rs1;
  logic       fwd_rs2;
  xlen_t      rs1_val;
  xlen_t      rs2_val;
  xlen_t      op1;
  xlen_t      op2;
  logic [5:0] shamt;
  xlen_t      alu_res;

  assign o_rs1_addr = i_dec.rs1_addr;
  assign o_rs2_addr = i_dec.rs2_addr;

  // older instruction still sitting in the result stage
  assign wb_hit  = o_wb.valid && o_wb.rd_wen;
  assign fwd_rs1 = wb_hit && (o_wb.rd_addr == i_dec.rs1_addr);
  assign fwd_rs2 = wb_hit && (o_wb.rd_addr == i_dec.rs2_addr);

  assign rs1_val = fwd_rs1 ? o_wb.rd_data : i_rs1_data;
  assign rs2_val = fwd_rs2 ? o_wb.rd_data : i_rs2_data;

  assign op1   = rs1_val;
  assign op2   = i_dec.op2_is_imm ? i_dec.imm : rs2_val;
  assign shamt = op2[5:0];

  always_comb begin
    case (i_dec.alu_op)
      `ALU_ADD:  alu_res = op1 + op2;
      `ALU_SUB:  alu_res = op1 - op2;
      `ALU_SLL:  alu_res = op1 << shamt;
      `ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      `ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, op1 < op2};
      `ALU_XOR:  alu_res = op1 ^ op2;
      `ALU_SRL:  alu_res = op1 >> shamt;
      `ALU_SRA:  alu_res = $signed(op1) >>> shamt;
      `ALU_OR:   alu_res = op1 | op2;
      `ALU_AND:  alu_res = op1 & op2;
      // upper immediate already shifted by decode
      `ALU_LUI:  alu_res = op2;
      default:   alu_res = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_wb.valid  <= 1'b0;
      o_wb.rd_wen <= 1'b0;
    end else begin
      o_wb.valid  <= i_dec.valid;
      o_wb.rd_wen <= i_dec.rd_wen;
    end
  end

  always_ff @(posedge clk) begin
    o_wb.rd_addr <= i_dec.rd_addr;
    o_wb.rd_data <= alu_res;
  end

endmodule

//--- rv_decode.sv
// rv_decode
// decodes an RV64I integer instruction and registers its control fields
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_decode
  import rv_core_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   i_instr_valid,
  input  instr_t i_instr,
  dec_ex_if.dec  o_dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  logic       legal;
  logic       is_imm;
  alu_op_t    alu_op;
  xlen_t      imm;

  // alt picks SUB or SRA
  function automatic alu_op_t sel_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      `F3_ADD:  sel_alu = alt ? `ALU_SUB : `ALU_ADD;
      `F3_SLL:  sel_alu = `ALU_SLL;
      `F3_SLT:  sel_alu = `ALU_SLT;
      `F3_SLTU: sel_alu = `ALU_SLTU;
      `F3_XOR:  sel_alu = `ALU_XOR;
      `F3_SR:   sel_alu = alt ? `ALU_SRA : `ALU_SRL;
      `F3_OR:   sel_alu = `ALU_OR;
      default:  sel_alu = `ALU_AND;
    endcase
  endfunction

  assign opcode = i_instr[6:0];
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];
  assign rd     = i_instr[11:7];

  always_comb begin
    legal  = 1'b0;
    is_imm = 1'b0;
    alu_op = `ALU_ADD;
    imm    = {{(`XLEN-12){i_instr[31]}}, i_instr[31:20]};
    case (opcode)
      `OPC_OP: begin
        // base encodings only, M extension and friends become bubbles
        legal  = (funct7 == `F7_BASE) ||
                 (funct7 == `F7_ALT && (funct3 == `F3_ADD || funct3 == `F3_SR));
        alu_op = sel_alu(funct3, funct7[5]);
      end
      `OPC_OP_IMM: begin
        legal  = 1'b1;
        is_imm = 1'b1;
        alu_op = sel_alu(funct3, funct3 == `F3_SR && funct7[5]);
      end
      `OPC_LUI: begin
        legal  = 1'b1;
        is_imm = 1'b1;
        alu_op = `ALU_LUI;
        imm    = {{(`XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_dec.valid  <= 1'b0;
      o_dec.rd_wen <= 1'b0;
    end else begin
      o_dec.valid  <= i_instr_valid;
      o_dec.rd_wen <= i_instr_valid && legal && (rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    o_dec.alu_op     <= alu_op;
    o_dec.rs1_addr   <= i_instr[19:15];
    o_dec.rs2_addr   <= i_instr[24:20];
    o_dec.rd_addr    <= rd;
    o_dec.op2_is_imm <= is_imm;
    o_dec.imm        <= imm;
  end

endmodule

//--- rv_core_if.sv
// rv_core stage interfaces
// decode-to-execute bundle and execute-to-result write-back bundle
`timescale 1ns/100ps

interface dec_ex_if
  import rv_core_pkg::*;
();
  logic      valid;
  alu_op_t   alu_op;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  logic      rd_wen;
  logic      op2_is_imm;
  xlen_t     imm;

  modport dec (
    output valid, alu_op, rs1_addr, rs2_addr, rd_addr, rd_wen, op2_is_imm, imm
  );

  modport ex (
    input valid, alu_op, rs1_addr, rs2_addr, rd_addr, rd_wen, op2_is_imm, imm
  );
endinterface

interface wb_if
  import rv_core_pkg::*;
();
  logic      valid;
  logic      rd_wen;
  reg_addr_t rd_addr;
  xlen_t     rd_data;

  modport src (output valid, rd_wen, rd_addr, rd_data);
  modport dst (input valid, rd_wen, rd_addr, rd_data);
endinterface

//--- rv_core_pkg.sv
// rv_core types
// vector typedefs shared by the pipeline stages and the testbench

`include "rv_core_defs.svh"

package rv_core_pkg;

  // register or ALU result value
  typedef logic [`XLEN-1:0] xlen_t;

  // register index
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // raw instruction word
  typedef logic [`INSTR_W-1:0] instr_t;

  // ALU operation select
  typedef logic [`ALU_OP_W-1:0] alu_op_t;

endpackage

//--- rv_core_defs.svh
// rv_core shared constants
// datapath widths, RV64I opcode and funct fields, ALU operation codes
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

`define XLEN       64
`define REG_ADDR_W 5
`define NUM_REGS   32
`define INSTR_W    32
`define ALU_OP_W   4

// major opcodes kept by the core
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111

`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000

`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_SLL  4'd2
`define ALU_SLT  4'd3
`define ALU_SLTU 4'd4
`define ALU_XOR  4'd5
`define ALU_SRL  4'd6
`define ALU_SRA  4'd7
`define ALU_OR   4'd8
`define ALU_AND  4'd9
`define ALU_LUI  4'd10

`endif
